//--- sim.f
+incdir+bench
src/loggerPkg.sv
src/uartRx.sv
src/byteFifo.sv
src/blockPort.sv
src/sectorSequencer.sv
src/blockSerializer.sv
src/sdLogger.sv
bench/tbSdLogger.sv

//--- run.sh
#!/bin/sh
# build and run the SD logger testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
  --top-module tbSdLogger \
  -f sim.f \
  -o simv
./obj_dir/simv

//--- bench/tbModel.svh
// tbModel: reference CRC and directory entry, plus typed compare tasks for the logger bench
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// crc-16, poly 0x1021, seed 0, one byte at a time msb first
function automatic crc16 refCrc(input sdByte bytes[$]);
  crc16 crc;
  int   b;
  crc = 16'h0000;
  foreach (bytes[i]) begin
    crc = crc ^ {bytes[i], 8'h00};
    for (b = 0; b < 8; b++) begin
      if (crc[15]) begin
        crc = {crc[14:0], 1'b0} ^ 16'h1021;
      end else begin
        crc = {crc[14:0], 1'b0};
      end
    end
  end
  return crc;
endfunction

// 32-byte short entry after the given number of data sectors
function automatic void refEntry(input int sectors, output sdByte entry[$]);
  string name;
  int    size;
  int    i;
  name = "LOG     DAT";
  size = sectors * BlockBytes;
  entry.delete();
  for (i = 0; i < BlockBytes; i++) begin
    entry.push_back(8'h00);
  end
  for (i = 0; i < 11; i++) begin
    entry[i] = name[i];
  end
  // archive attribute
  entry[11] = 8'h20;
  entry[26] = FirstCluster[7:0];
  entry[27] = FirstCluster[15:8];
  // size little endian
  entry[28] = size[7:0];
  entry[29] = size[15:8];
  entry[30] = size[23:16];
  entry[31] = size[31:24];
endfunction

// ----------------------------------------
// compare tasks
// ----------------------------------------
task automatic checkByte(input string name, input sdByte got, input sdByte exp);
  if (got !== exp) begin
    abortRun($sformatf("[FAIL] %0t %s got %02h expected %02h", $time, name, got, exp));
  end
endtask

task automatic checkAddr(input string name, input sectorAddr got, input sectorAddr exp);
  if (got !== exp) begin
    abortRun($sformatf("[FAIL] %0t %s got %08h expected %08h", $time, name, got, exp));
  end
endtask

task automatic checkCrc(input string name, input crc16 got, input crc16 exp);
  if (got !== exp) begin
    abortRun($sformatf("[FAIL] %0t %s got %04h expected %04h", $time, name, got, exp));
  end
endtask

`endif

//--- bench/tbSdLogger.sv
// tbSdLogger: UART stimulus into the SD logger, DAT0 frame monitor and block checker
`timescale 1ns/1ps
module tbSdLogger import loggerPkg::*; ();

  localparam int ByteClks   = 10 * ClksPerBit;
  localparam int BlockClks  = (BlockBytes * 8 + 18) * 2 + 1;
  localparam int TotalBytes = 96;
  localparam int NumFrames  = 6;
  // idle wait with one byte short of a block
  localparam int QuietClks  = 4 * BlockClks;
  localparam longint WatchdogNs =
    10 * (2 * TotalBytes * ByteClks + 2 * NumFrames * BlockClks + QuietClks + 200);

  logic      clk;
  logic      rstn;
  logic      rx;
  logic      sdClk;
  logic      sdDat;
  sectorAddr blockAddr;
  logic      blockActive;

  sdByte     sentBytes[$];
  // bytes whose stop bit is about to go out
  int        bytesFramed = 0;
  // frames seen on the line, bytes flattened
  sdByte     frameData[$];
  sectorAddr frameAddr[$];
  crc16      frameCrc[$];
  logic      frameEnd[$];
  // bytes framed when each start bit was seen
  int        framedAtStart[$];
  int        framesChecked;

  sdLogger i_dut (
    .clk         (clk),
    .rstn        (rstn),
    .rx          (rx),
    .sdClk       (sdClk),
    .sdDat       (sdDat),
    .blockAddr   (blockAddr),
    .blockActive (blockActive)
  );

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "stopping at first error");
  endtask

  `include "tbModel.svh"

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ----------------------------------------
  // UART stimulus
  // ----------------------------------------
  task automatic driveBit(input logic v);
    @(posedge clk);
    rx <= v;
    repeat (ClksPerBit - 1) @(posedge clk);
  endtask

  // 8N1, lsb first
  task automatic sendByte(input sdByte b);
    int i;
    sentBytes.push_back(b);
    driveBit(1'b0);
    for (i = 0; i < 8; i++) begin
      driveBit(b[i]);
    end
    // counted one clk before the stop bit
    bytesFramed++;
    driveBit(1'b1);
  endtask

  // ----------------------------------------
  // DAT0 frame monitor
  // ----------------------------------------
  logic      inFrame = 1'b0;
  int        bitPos;
  sdByte     curByte;
  crc16      curCrc;
  sectorAddr curAddr;
  time       lastEnd = 0;

  always @(posedge sdClk) begin
    if (!blockActive) begin
      abortRun("sdClk toggled while blockActive was low");
    end
    if (!inFrame) begin
      if (sdDat !== 1'b0) begin
        abortRun("sdClk running with no start bit on sdDat");
      end
      // end bit cell plus 8 idle sdClk periods
      if (lastEnd != 0 && $time - lastEnd < 180) begin
        abortRun("idle gap between blocks shorter than 8 sdClk periods");
      end
      inFrame = 1'b1;
      bitPos  = 0;
      curAddr = blockAddr;
      framedAtStart.push_back(bytesFramed);
    end else begin
      bitPos++;
      checkAddr("blockAddr", blockAddr, curAddr);
      if (bitPos <= BlockBytes * 8) begin
        curByte = {curByte[6:0], sdDat};
        if (bitPos % 8 == 0) begin
          frameData.push_back(curByte);
        end
      end else if (bitPos <= BlockBytes * 8 + 16) begin
        curCrc = {curCrc[14:0], sdDat};
      end else begin
        frameEnd.push_back(sdDat);
        frameCrc.push_back(curCrc);
        frameAddr.push_back(curAddr);
        lastEnd = $time;
        inFrame = 1'b0;
      end
    end
  end

  // ----------------------------------------
  // checker, data and entry frames alternate
  // ----------------------------------------
  initial begin
    sdByte     expBytes[$];
    sdByte     gotByte;
    sectorAddr gotAddr;
    int        blockIdx;
    int        framed;
    int        i;
    framesChecked = 0;
    for (int f = 0; f < NumFrames; f++) begin
      while (frameAddr.size() == 0) @(posedge clk);
      gotAddr  = frameAddr.pop_front();
      framed   = framedAtStart.pop_front();
      blockIdx = f / 2;
      expBytes.delete();
      if (f % 2 == 0) begin
        checkAddr("blockAddr", gotAddr, DataBase + sectorAddr'(blockIdx));
        if (framed < (blockIdx + 1) * BlockBytes) begin
          abortRun("data block started before a full block of bytes was received");
        end
        for (i = 0; i < BlockBytes; i++) begin
          expBytes.push_back(sentBytes[blockIdx * BlockBytes + i]);
        end
      end else begin
        checkAddr("blockAddr", gotAddr, DirSector);
        refEntry(blockIdx + 1, expBytes);
      end
      for (i = 0; i < BlockBytes; i++) begin
        gotByte = frameData.pop_front();
        checkByte($sformatf("sdDat frame %0d byte %0d", f, i), gotByte, expBytes[i]);
      end
      checkCrc($sformatf("sdDat frame %0d crc", f), frameCrc.pop_front(), refCrc(expBytes));
      if (frameEnd.pop_front() !== 1'b1) begin
        abortRun($sformatf("end bit of frame %0d was not high", f));
      end
      framesChecked++;
    end
  end

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    rx   = 1'b1;
    rstn = 1'b0;
    void'($urandom(71));
    repeat (4) @(posedge clk);
    rstn <= 1'b1;
    repeat (20) @(posedge clk);
    for (int n = 0; n < BlockBytes - 1; n++) begin
      sendByte(sdByte'($urandom()));
    end
    // one byte short, line must stay quiet
    repeat (QuietClks) begin
      @(negedge clk);
      if (blockActive !== 1'b0 || sdDat !== 1'b1) begin
        abortRun("block started with only 31 bytes buffered");
      end
    end
    for (int n = BlockBytes - 1; n < TotalBytes; n++) begin
      sendByte(sdByte'($urandom()));
    end
    while (framesChecked < NumFrames) @(posedge clk);
    repeat (2 * BlockClks) @(posedge clk);
    if (frameAddr.size() != 0 || blockActive !== 1'b0) begin
      abortRun("extra block after the last entry update");
    end
    $display("Finished with no errors");
    $finish;
  end

  initial begin
    #(WatchdogNs);
    abortRun("watchdog timeout, expected blocks never completed");
  end

endmodule

//--- src/sdLogger.sv
// sdLogger: UART byte logger top, writes data blocks and directory entry updates on DAT0
`timescale 1ns/1ps
module sdLogger import loggerPkg::*; (
  input  logic      clk,
  input  logic      rstn,
  input  logic      rx,
  output logic      sdClk,
  output logic      sdDat,
  output sectorAddr blockAddr,
  output logic      blockActive
);

  // receiver to fifo
  sdByte    rxByte;
  logic     rxStrobe;
  // fifo to sequencer
  sdByte    head;
  fifoCount count;
  logic     pop;

  // sequencer to serializer
  blockPort blk ();

  // ----------------------------------------
  // stages
  // ----------------------------------------
  uartRx rxStage (
    .clk      (clk),
    .rstn     (rstn),
    .rx       (rx),
    .rxByte   (rxByte),
    .rxStrobe (rxStrobe)
  );

  // soaks up uart bytes while a block is on the line
  byteFifo fifoStage (
    .clk      (clk),
    .rstn     (rstn),
    .wrByte   (rxByte),
    .wrStrobe (rxStrobe),
    .pop      (pop),
    .head     (head),
    .count    (count)
  );

  sectorSequencer seqStage (
    .clk         (clk),
    .rstn        (rstn),
    .head        (head),
    .count       (count),
    .pop         (pop),
    .blk         (blk),
    .blockAddr   (blockAddr),
    .blockActive (blockActive)
  );

  blockSerializer serStage (
    .clk   (clk),
    .rstn  (rstn),
    .blk   (blk),
    .sdClk (sdClk),
    .sdDat (sdDat)
  );

endmodule

//--- src/blockSerializer.sv
// blockSerializer: drives sdClk and frames a block on DAT0 with start bit, CRC-16 and end bit
`timescale 1ns/1ps
module blockSerializer import loggerPkg::*; (
  input  logic     clk,
  input  logic     rstn,
  blockPort.sink   blk,
  output logic     sdClk,
  output logic     sdDat
);

  logic                    busy;
  logic [FrameIdxBits-1:0] bitIdx;
  logic [FrameIdxBits-1:0] nextIdx;
  logic                    lastBit;
  logic                    advance;
  logic                    inData;
  logic                    newByte;
  logic                    inCrc;
  logic                    dataBit;
  sdByte                   shReg;
  crc16                    crc;

  // ----------------------------------------
  // bit position decode
  // ----------------------------------------
  // bit 0 is the start bit, data from 1, crc after, end bit last
  assign lastBit = (bitIdx == FrameIdxBits'(FrameBits - 1));
  // sdClk falling, next bit goes out
  assign advance = busy && sdClk && !lastBit;
  assign nextIdx = bitIdx + 1'b1;
  assign inData  = (nextIdx <= FrameIdxBits'(DataBits));
  // first bit of every byte takes a fresh byte
  assign newByte = inData && (nextIdx[2:0] == 3'd1);
  assign inCrc   = !inData && (nextIdx <= FrameIdxBits'(DataBits + $bits(crc16)));
  // msb first
  assign dataBit = newByte ? blk.data[7] : shReg[7];

  // ----------------------------------------
  // clock, line and handshake
  // ----------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      busy     <= 1'b0;
      sdClk    <= 1'b0;
      sdDat    <= 1'b1;
      bitIdx   <= '0;
      blk.take <= 1'b0;
      blk.done <= 1'b0;
    end else begin
      blk.take <= 1'b0;
      blk.done <= 1'b0;
      if (!busy) begin
        // start bit out while sdClk still low
        if (blk.start) begin
          busy   <= 1'b1;
          bitIdx <= '0;
          sdDat  <= 1'b0;
        end
      end else if (!sdClk) begin
        // rising edge, card samples
        sdClk <= 1'b1;
      end else begin
        sdClk <= 1'b0;
        if (lastBit) begin
          // end bit already high, line stays idle
          busy     <= 1'b0;
          blk.done <= 1'b1;
        end else begin
          bitIdx   <= nextIdx;
          blk.take <= newByte;
          if (inData) begin
            sdDat <= dataBit;
          end else if (inCrc) begin
            sdDat <= crc[15];
          end else begin
            sdDat <= 1'b1;
          end
        end
      end
    end
  end

  // ----------------------------------------
  // shift register and crc
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!busy && blk.start) begin
      crc <= '0;
    end else if (advance) begin
      if (newByte) begin
        shReg <= {blk.data[6:0], 1'b0};
      end else begin
        shReg <= {shReg[6:0], 1'b0};
      end
      // accumulate over data, then shift out the remainder
      if (inData) begin
        crc <= crcStep(crc, dataBit);
      end else begin
        crc <= {crc[14:0], 1'b0};
      end
    end
  end

  // sequencer must wait for done before the next block
  assert property (@(posedge clk) disable iff (!rstn)
    blk.start |-> !busy)
    else $error("blockSerializer start while a block is in flight");

endmodule

//--- src/sectorSequencer.sv
// sectorSequencer: alternates data blocks and directory entry updates, feeds bytes and addresses
`timescale 1ns/1ps
module sectorSequencer import loggerPkg::*; (
  input  logic            clk,
  input  logic            rstn,
  input  sdByte           head,
  input  fifoCount        count,
  output logic            pop,
  blockPort.source        blk,
  output sectorAddr       blockAddr,
  output logic            blockActive
);

  typedef enum logic [1:0] {SeqIdle, SeqData, SeqDirWait, SeqEntry} seqState;

  seqState                state;
  sectorAddr              sectorCount;
  sectorAddr              fileSize;
  logic [ByteIdxBits-1:0] byteIdx;
  logic [GapCntBits-1:0]  gapCnt;
  logic                   gapDone;
  sdByte                  entryByte;

  assign gapDone  = (gapCnt == '0);
  assign fileSize = sectorAddr'(sectorCount * BlockBytes);

  // data phase streams the fifo head, one pop per take
  assign pop      = blk.take && (state == SeqData);
  assign blk.data = (state == SeqEntry) ? entryByte : head;

  // ----------------------------------------
  // 32-byte directory entry
  // ----------------------------------------
  always_comb begin
    entryByte = '0;
    if (byteIdx < ByteIdxBits'(11)) begin
      // name bytes, first char sits in the top byte
      entryByte = FileName[(10 - byteIdx) * 8 +: 8];
    end else begin
      case (byteIdx)
        // archive attribute
        5'd11:   entryByte = 8'h20;
        // low word of start cluster, high word at 20-21 stays zero
        5'd26:   entryByte = FirstCluster[7:0];
        5'd27:   entryByte = FirstCluster[15:8];
        // file size, little endian
        5'd28:   entryByte = fileSize[7:0];
        5'd29:   entryByte = fileSize[15:8];
        5'd30:   entryByte = fileSize[23:16];
        5'd31:   entryByte = fileSize[31:24];
        default: entryByte = '0;
      endcase
    end
  end

  // ----------------------------------------
  // block FSM
  // ----------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state       <= SeqIdle;
      sectorCount <= '0;
      blockAddr   <= '0;
      blockActive <= 1'b0;
      blk.start   <= 1'b0;
      byteIdx     <= '0;
      gapCnt      <= '0;
    end else begin
      blk.start <= 1'b0;
      // line idle time between blocks
      if (!gapDone) begin
        gapCnt <= gapCnt - 1'b1;
      end
      case (state)
        SeqIdle: begin
          if (gapDone && count >= fifoCount'(BlockBytes)) begin
            blockAddr   <= DataBase + sectorCount;
            blockActive <= 1'b1;
            blk.start   <= 1'b1;
            state       <= SeqData;
          end
        end
        SeqData: begin
          if (blk.done) begin
            sectorCount <= sectorCount + 1'b1;
            blockActive <= 1'b0;
            gapCnt      <= GapCntBits'(GapClks);
            state       <= SeqDirWait;
          end
        end
        SeqDirWait: begin
          // entry goes out right after the gap
          if (gapDone) begin
            blockAddr   <= DirSector;
            blockActive <= 1'b1;
            blk.start   <= 1'b1;
            byteIdx     <= '0;
            state       <= SeqEntry;
          end
        end
        default: begin
          if (blk.take) begin
            byteIdx <= byteIdx + 1'b1;
          end
          if (blk.done) begin
            blockActive <= 1'b0;
            gapCnt      <= GapCntBits'(GapClks);
            state       <= SeqIdle;
          end
        end
      endcase
    end
  end

endmodule

//--- src/blockPort.sv
// blockPort: byte stream of one block from sequencer to serializer
`timescale 1ns/1ps
interface blockPort import loggerPkg::*; ();

  // one-clk pulse, opens a block
  logic  start;
  // byte used at the next take
  sdByte data;
  // one-clk pulse per byte latched
  logic  take;
  // one-clk pulse after the end bit
  logic  done;

  // sequencer side
  modport source (
    output start,
    output data,
    input  take,
    input  done
  );

  // serializer side
  modport sink (
    input  start,
    input  data,
    output take,
    output done
  );

endinterface

//--- src/byteFifo.sv
// byteFifo: show-ahead circular byte buffer between UART receiver and sequencer
`timescale 1ns/1ps
module byteFifo import loggerPkg::*; (
  input  logic     clk,
  input  logic     rstn,
  input  sdByte    wrByte,
  input  logic     wrStrobe,
  input  logic     pop,
  output sdByte    head,
  output fifoCount count
);

  sdByte                  mem [FifoDepth];
  logic [FifoPtrBits-1:0] wrPtr;
  logic [FifoPtrBits-1:0] rdPtr;
  logic                   doWrite;
  logic                   doRead;

  // full drops the byte, empty ignores the pop
  assign doWrite = wrStrobe && (count != fifoCount'(FifoDepth));
  assign doRead  = pop && (count != '0);

  // head visible with no read latency
  assign head = mem[rdPtr];

  // ----------------------------------------
  // storage
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (doWrite) begin
      mem[wrPtr] <= wrByte;
    end
  end

  // ----------------------------------------
  // pointers and fill level
  // ----------------------------------------
  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doWrite) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (doRead) begin
        rdPtr <= rdPtr + 1'b1;
      end
      case ({doWrite, doRead})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // uart outran the card, a byte is gone
  assert property (@(posedge clk) disable iff (!rstn)
    wrStrobe |-> count != fifoCount'(FifoDepth))
    else $error("byteFifo overflow, received byte lost");

  // sequencer only starts a block with a full block buffered
  assert property (@(posedge clk) disable iff (!rstn)
    pop |-> count != '0)
    else $error("byteFifo pop while empty");

endmodule

//--- src/uartRx.sv
// uartRx: 8N1 receiver, samples each bit mid-cell and strobes good bytes
`timescale 1ns/1ps
module uartRx import loggerPkg::*; (
  input  logic  clk,
  input  logic  rstn,
  input  logic  rx,
  output sdByte rxByte,
  output logic  rxStrobe
);

  typedef enum logic [1:0] {RxIdle, RxStart, RxData, RxStop} rxState;

  rxState                 state;
  logic                   rxMeta;
  logic                   rxSync;
  logic [BaudCntBits-1:0] baudCnt;
  logic [2:0]             bitIdx;
  logic                   halfTick;
  logic                   bitTick;
  sdByte                  shiftReg;

  // ----------------------------------------
  // input synchronizer
  // ----------------------------------------
  // line idles high, so reset to 1
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rxMeta <= 1'b1;
      rxSync <= 1'b1;
    end else begin
      rxMeta <= rx;
      rxSync <= rxMeta;
    end
  end

  // mid start bit / one full bit later
  assign halfTick = (baudCnt == BaudCntBits'(ClksPerBit / 2 - 1));
  assign bitTick  = (baudCnt == BaudCntBits'(ClksPerBit - 1));

  // ----------------------------------------
  // frame FSM
  // ----------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state    <= RxIdle;
      baudCnt  <= '0;
      bitIdx   <= '0;
      rxStrobe <= 1'b0;
    end else begin
      rxStrobe <= 1'b0;
      case (state)
        RxIdle: begin
          // detection cycle counts as the first of the half bit
          if (!rxSync) begin
            baudCnt <= BaudCntBits'(1);
            state   <= RxStart;
          end
        end
        RxStart: begin
          if (halfTick) begin
            baudCnt <= '0;
            bitIdx  <= '0;
            // glitch, not a real start bit
            state   <= rxSync ? RxIdle : RxData;
          end else begin
            baudCnt <= baudCnt + 1'b1;
          end
        end
        RxData: begin
          if (bitTick) begin
            baudCnt <= '0;
            bitIdx  <= bitIdx + 1'b1;
            if (bitIdx == 3'd7) begin
              state <= RxStop;
            end
          end else begin
            baudCnt <= baudCnt + 1'b1;
          end
        end
        default: begin
          // stop bit must be high, else the frame is dropped
          if (bitTick) begin
            baudCnt  <= '0;
            rxStrobe <= rxSync;
            state    <= RxIdle;
          end else begin
            baudCnt <= baudCnt + 1'b1;
          end
        end
      endcase
    end
  end

  // lsb first into the top, byte settles after bit 7
  always_ff @(posedge clk) begin
    if (state == RxData && bitTick) begin
      shiftReg <= {rxSync, shiftReg[7:1]};
    end
  end

  assign rxByte = shiftReg;

endmodule

//--- src/loggerPkg.sv
// loggerPkg: shared types, constants and the data-line CRC step for the SD logger
package loggerPkg;

  // ----------------------------------------
  // types
  // ----------------------------------------
  typedef logic [7:0]  sdByte;
  typedef logic [31:0] sectorAddr;
  typedef logic [15:0] crc16;
  // holds 0..FifoDepth inclusive
  typedef logic [6:0]  fifoCount;

  // ----------------------------------------
  // sizes and timing
  // ----------------------------------------
  // short blocks, one directory entry per block
  localparam int BlockBytes  = 32;
  localparam int FifoDepth   = 64;
  localparam int ClksPerBit  = 16;

  localparam int FifoPtrBits = $clog2(FifoDepth);
  localparam int BaudCntBits = $clog2(ClksPerBit);
  localparam int ByteIdxBits = $clog2(BlockBytes);

  // frame is start bit, data, crc, end bit
  localparam int DataBits     = BlockBytes * 8;
  localparam int FrameBits    = DataBits + 18;
  localparam int FrameIdxBits = $clog2(FrameBits);

  // idle gap between blocks, 8 sdClk periods
  localparam int GapClks    = 16;
  localparam int GapCntBits = $clog2(GapClks + 1);

  // ----------------------------------------
  // file placement on the card
  // ----------------------------------------
  localparam sectorAddr DataBase  = 32'h0000_0840;
  localparam sectorAddr DirSector = 32'h0000_0800;
  localparam logic [15:0] FirstCluster = 16'd3;
  // 8.3 short name, space padded, first char in the top byte
  localparam logic [8*11-1:0] FileName = "LOG     DAT";

  // one bit of CRC-16/XMODEM, poly 0x1021, seed 0
  function automatic crc16 crcStep(input crc16 crc, input logic din);
    logic fb;
    fb = crc[15] ^ din;
    return {crc[14:0], 1'b0} ^ (fb ? 16'h1021 : 16'h0000);
  endfunction

endpackage
